//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111
   } opcode_e;

   localparam logic [2:0] F3_ADD = 3'b000;   // add and addi
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_LW  = 3'b010;
   localparam logic [2:0] F3_SW  = 3'b010;
   localparam logic [6:0] F7_ADD = 7'b0000000;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
   } s_fmt_t;

   // Offset bit 0 is implied zero
   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      j_fmt_t j;
   } instr_u;

endpackage

//--- verilog/core_pkg.sv
package core_pkg;

   typedef logic [31:0] word_t;

   // One-hot, all zero means illegal
   typedef struct packed {
      logic addi;
      logic add;
      logic beq;
      logic jal;
      logic lw;
      logic sw;
   } instructions;

   typedef struct packed {
      instructions instr;
      logic        illegal;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      word_t       imm;
   } dec_t;

   // Request is held until the grant pulse
   typedef struct packed {
      logic  req;
      logic  we;
      word_t addr;   // Byte address
      word_t wdata;
   } mem_req_t;

endpackage

//--- verilog/decoder.sv
module decoder (
   input  core_pkg::word_t instr_raw,
   output core_pkg::dec_t  dec
);

   rv_isa_pkg::instr_u iw;
   logic               r_fmt;
   logic               i_fmt;
   logic               s_fmt;
   logic               b_fmt;
   logic               j_fmt;

   assign iw = instr_raw;

   // Opcode sits at the same place in every view
   assign r_fmt = iw.r.opcode == rv_isa_pkg::OP;
   assign i_fmt = iw.r.opcode == rv_isa_pkg::OP_IMM || iw.r.opcode == rv_isa_pkg::LOAD;
   assign s_fmt = iw.r.opcode == rv_isa_pkg::STORE;
   assign b_fmt = iw.r.opcode == rv_isa_pkg::BRANCH;
   assign j_fmt = iw.r.opcode == rv_isa_pkg::JAL;

   always_comb begin
      dec = '0;

      dec.instr.add  = r_fmt && iw.r.funct3 == rv_isa_pkg::F3_ADD
                       && iw.r.funct7 == rv_isa_pkg::F7_ADD;
      dec.instr.addi = iw.r.opcode == rv_isa_pkg::OP_IMM && iw.r.funct3 == rv_isa_pkg::F3_ADD;
      dec.instr.lw   = iw.r.opcode == rv_isa_pkg::LOAD && iw.r.funct3 == rv_isa_pkg::F3_LW;
      dec.instr.sw   = s_fmt && iw.r.funct3 == rv_isa_pkg::F3_SW;
      dec.instr.beq  = b_fmt && iw.r.funct3 == rv_isa_pkg::F3_BEQ;
      dec.instr.jal  = j_fmt;
      dec.illegal    = dec.instr == '0;

      dec.rd  = (r_fmt || i_fmt || j_fmt) ? iw.r.rd : 5'd0;
      dec.rs1 = (r_fmt || i_fmt || s_fmt || b_fmt) ? iw.r.rs1 : 5'd0;
      dec.rs2 = (r_fmt || s_fmt || b_fmt) ? iw.r.rs2 : 5'd0;

      if (i_fmt) begin
         dec.imm = {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
      end else if (s_fmt) begin
         dec.imm = {{20{iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
      end else if (b_fmt) begin
         dec.imm = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11,
                    iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
      end else if (j_fmt) begin
         dec.imm = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12,
                    iw.j.imm_11, iw.j.imm_10_1, 1'b0};
      end
   end

endmodule

//--- verilog/reg_file.sv
module reg_file (
   input  logic            clk,
   input  logic            rst_n,
   input  logic [4:0]      raddr1,
   input  logic [4:0]      raddr2,
   output core_pkg::word_t rdata1,
   output core_pkg::word_t rdata2,
   input  logic            we,
   input  logic [4:0]      waddr,
   input  core_pkg::word_t wdata
);

   core_pkg::word_t regs [1:31];   // x0 has no storage

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && waddr != 5'd0) begin
         regs[waddr] <= wdata;
      end
   end

   assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
   assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- verilog/exec_unit.sv
module exec_unit (
   input  core_pkg::dec_t  dec,
   input  core_pkg::word_t pc,
   input  core_pkg::word_t rs1_val,
   input  core_pkg::word_t rs2_val,
   output core_pkg::word_t alu_res,
   output core_pkg::word_t next_pc,
   output core_pkg::word_t link
);

   core_pkg::word_t op_b;
   logic            src_eq;
   logic            take;

   // addi, lw and sw all add the immediate
   assign op_b    = dec.instr.add ? rs2_val : dec.imm;
   assign alu_res = rs1_val + op_b;

   assign src_eq  = rs1_val == rs2_val;
   assign take    = (dec.instr.beq && src_eq) || dec.instr.jal;

   assign link    = pc + 32'd4;
   assign next_pc = take ? pc + dec.imm : link;   // PC relative

endmodule

//--- verilog/lsu.sv
module lsu (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               start,
   input  core_pkg::dec_t     dec,
   input  core_pkg::word_t    addr,
   input  core_pkg::word_t    store_data,
   input  logic               gnt,
   input  logic               rvalid,
   input  core_pkg::word_t    rdata,
   output core_pkg::mem_req_t req,
   output logic               done,
   output core_pkg::word_t    load_data
);

   logic            pending;    // Waiting for grant
   logic            wait_rsp;   // Granted, waiting for rvalid or the store slot
   logic            is_load;
   core_pkg::word_t addr_q;
   core_pkg::word_t data_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending  <= 1'b0;
         wait_rsp <= 1'b0;
         is_load  <= 1'b0;
      end else begin
         if (start) begin
            pending <= 1'b1;
            is_load <= dec.instr.lw;
         end else if (pending && gnt) begin
            pending <= 1'b0;
         end
         if (pending && gnt) begin
            wait_rsp <= 1'b1;
         end else if (done) begin
            wait_rsp <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         addr_q <= addr;
         data_q <= store_data;
      end
   end

   assign req.req   = pending;
   assign req.we    = !is_load;
   assign req.addr  = addr_q;
   assign req.wdata = data_q;

   assign done      = wait_rsp && (is_load ? rvalid : 1'b1);
   assign load_data = rdata;

   a_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      req.req |-> req.addr[1:0] == 2'b00);

endmodule

//--- verilog/core_sequencer.sv
module core_sequencer (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               run,
   input  core_pkg::dec_t     dec,
   input  core_pkg::word_t    next_pc,
   input  core_pkg::word_t    link,
   input  core_pkg::word_t    alu_res,
   input  logic               fetch_gnt,
   input  logic               fetch_rvalid,
   input  core_pkg::word_t    rdata,
   input  logic               lsu_done,
   input  core_pkg::word_t    load_data,
   output core_pkg::mem_req_t fetch_req,
   output core_pkg::word_t    instr_word,
   output core_pkg::word_t    pc,
   output logic               lsu_start,
   output logic               rf_we,
   output logic [4:0]         rf_waddr,
   output core_pkg::word_t    rf_wdata,
   output logic               halted
);

   localparam logic [2:0] S_IDLE  = 3'd0;
   localparam logic [2:0] S_FETCH = 3'd1;
   localparam logic [2:0] S_WAIT  = 3'd2;
   localparam logic [2:0] S_EXEC  = 3'd3;
   localparam logic [2:0] S_MEM   = 3'd4;
   localparam logic [2:0] S_HALT  = 3'd5;

   logic [2:0]      state;
   core_pkg::word_t ir;
   logic            is_mem;
   logic            retire;

   assign is_mem = dec.instr.lw || dec.instr.sw;
   assign retire = (state == S_EXEC && !dec.illegal && !is_mem)
                   || (state == S_MEM && lsu_done);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= S_IDLE;
         pc    <= '0;
      end else begin
         case (state)
            S_IDLE:  if (run) state <= S_FETCH;
            S_FETCH: if (fetch_gnt) state <= S_WAIT;
            S_WAIT:  if (fetch_rvalid) state <= S_EXEC;
            S_EXEC: begin
               if (dec.illegal) begin
                  state <= S_HALT;
               end else if (is_mem) begin
                  state <= S_MEM;
               end
            end
            default: ;   // Halt only leaves on reset
         endcase
         if (retire) begin
            pc    <= next_pc;
            state <= run ? S_FETCH : S_IDLE;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_WAIT && fetch_rvalid) begin
         ir <= rdata;
      end
   end

   assign fetch_req.req   = state == S_FETCH;
   assign fetch_req.we    = 1'b0;
   assign fetch_req.addr  = pc;
   assign fetch_req.wdata = '0;

   assign instr_word = ir;
   assign lsu_start  = state == S_EXEC && is_mem;

   // Write-back from execute for ALU and jal, from memory stage for lw
   assign rf_we    = (state == S_EXEC && (dec.instr.addi || dec.instr.add || dec.instr.jal))
                     || (state == S_MEM && lsu_done && dec.instr.lw);
   assign rf_waddr = dec.rd;
   assign rf_wdata = dec.instr.lw ? load_data : (dec.instr.jal ? link : alu_res);

   assign halted = state == S_HALT || (state == S_EXEC && dec.illegal);

   a_no_fetch_halted : assert property (@(posedge clk) disable iff (!rst_n)
      halted |=> halted && !fetch_req.req);

endmodule

//--- verilog/mem_arbiter.sv
module mem_arbiter #(
   parameter int MEM_AW = 10
) (
   input  logic               clk,
   input  logic               rst_n,
   input  core_pkg::mem_req_t fetch_req,
   input  core_pkg::mem_req_t lsu_req,
   input  core_pkg::mem_req_t dbg_req,
   output logic               fetch_gnt,
   output logic               lsu_gnt,
   output logic               dbg_gnt,
   output logic               fetch_rvalid,
   output logic               lsu_rvalid,
   output logic               dbg_rvalid,
   output logic               mem_en,
   output logic               mem_we,
   output logic [MEM_AW-1:0]  mem_addr,
   output core_pkg::word_t    mem_wdata
);

   logic [2:0]         gnt;        // {dbg, lsu, fetch}
   logic [2:0]         rd_owner;   // Outstanding read, one-hot
   core_pkg::mem_req_t sel;

   always_comb begin
      gnt = '0;
      if (rd_owner == '0) begin
         if (dbg_req.req) begin
            gnt[2] = 1'b1;
         end else if (lsu_req.req) begin
            gnt[1] = 1'b1;
         end else if (fetch_req.req) begin
            gnt[0] = 1'b1;
         end
      end
   end

   assign sel = gnt[2] ? dbg_req : (gnt[1] ? lsu_req : fetch_req);

   assign mem_en    = |gnt;
   assign mem_we    = mem_en && sel.we;
   assign mem_addr  = sel.addr[MEM_AW+1:2];   // Word address
   assign mem_wdata = sel.wdata;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_owner <= '0;
      end else begin
         rd_owner <= (mem_en && !sel.we) ? gnt : 3'b000;
      end
   end

   assign {dbg_gnt, lsu_gnt, fetch_gnt}          = gnt;
   assign {dbg_rvalid, lsu_rvalid, fetch_rvalid} = rd_owner;

   a_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(gnt) && $onehot0(rd_owner));

   a_read_gap : assert property (@(posedge clk) disable iff (!rst_n)
      mem_en && !mem_we |=> gnt == 3'b000);

endmodule

//--- verilog/unified_mem.sv
module unified_mem #(
   parameter int MEM_AW = 10
) (
   input  logic              clk,
   input  logic              en,
   input  logic              we,
   input  logic [MEM_AW-1:0] addr,
   input  core_pkg::word_t   wdata,
   output core_pkg::word_t   rdata
);

   localparam int DEPTH = 1 << MEM_AW;

   core_pkg::word_t mem [0:DEPTH-1];

   // Write or registered read, never both
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;
         end else begin
            rdata <= mem[addr];
         end
      end
   end

endmodule

//--- verilog/rv_core_top.sv
module rv_core_top #(
   parameter int MEM_AW = 10
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               run,
   input  core_pkg::mem_req_t dbg_req,
   output logic               dbg_gnt,
   output logic               dbg_rvalid,
   output core_pkg::word_t    dbg_rdata,
   output logic               halted
);

   core_pkg::dec_t     dec;
   core_pkg::word_t    instr_word;
   core_pkg::word_t    pc;
   core_pkg::word_t    next_pc;
   core_pkg::word_t    link;
   core_pkg::word_t    alu_res;
   core_pkg::word_t    rs1_val;
   core_pkg::word_t    rs2_val;
   core_pkg::word_t    load_data;
   core_pkg::word_t    rf_wdata;
   core_pkg::word_t    mem_rdata;
   core_pkg::word_t    mem_wdata;
   core_pkg::mem_req_t fetch_req;
   core_pkg::mem_req_t lsu_req;
   logic               fetch_gnt;
   logic               fetch_rvalid;
   logic               lsu_gnt;
   logic               lsu_rvalid;
   logic               lsu_start;
   logic               lsu_done;
   logic               rf_we;
   logic [4:0]         rf_waddr;
   logic               mem_en;
   logic               mem_we;
   logic [MEM_AW-1:0]  mem_addr;

   core_sequencer u_seq (
      .clk, .rst_n, .run, .dec, .next_pc, .link, .alu_res,
      .fetch_gnt, .fetch_rvalid, .rdata(mem_rdata), .lsu_done, .load_data,
      .fetch_req, .instr_word, .pc, .lsu_start, .rf_we, .rf_waddr, .rf_wdata, .halted
   );

   decoder u_dec (.instr_raw(instr_word), .dec);

   reg_file u_rf (
      .clk, .rst_n, .raddr1(dec.rs1), .raddr2(dec.rs2),
      .rdata1(rs1_val), .rdata2(rs2_val),
      .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
   );

   exec_unit u_exec (.dec, .pc, .rs1_val, .rs2_val, .alu_res, .next_pc, .link);

   lsu u_lsu (
      .clk, .rst_n, .start(lsu_start), .dec, .addr(alu_res), .store_data(rs2_val),
      .gnt(lsu_gnt), .rvalid(lsu_rvalid), .rdata(mem_rdata),
      .req(lsu_req), .done(lsu_done), .load_data
   );

   mem_arbiter #(.MEM_AW(MEM_AW)) u_arb (
      .clk, .rst_n, .fetch_req, .lsu_req, .dbg_req,
      .fetch_gnt, .lsu_gnt, .dbg_gnt, .fetch_rvalid, .lsu_rvalid, .dbg_rvalid,
      .mem_en, .mem_we, .mem_addr, .mem_wdata
   );

   unified_mem #(.MEM_AW(MEM_AW)) u_mem (
      .clk, .en(mem_en), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
   );

   assign dbg_rdata = mem_rdata;   // Shared read bus, qualified by dbg_rvalid

endmodule

//--- sim/tb_rv_core.sv
module tb_rv_core;

   localparam int              CLK_PERIOD = 40;
   localparam int              DRIVE_DLY  = 5;
   localparam int              RST_CYCLES = 8;
   localparam int              NUM_TESTS  = 5;
   localparam int              MEM_AW     = 10;
   localparam core_pkg::word_t RES_ADDR   = 32'h100;
   localparam core_pkg::word_t DATA_ADDR  = 32'h200;
   localparam core_pkg::word_t PRELOAD    = 32'h5a5a_1234;
   localparam core_pkg::word_t MARKER     = 32'hdead_beef;   // Result slot before each run

   typedef struct packed {
      logic [11:0][31:0] prog;
      core_pkg::word_t   res_addr;
      core_pkg::word_t   exp_val;
      logic              rnd;   // Immediates drawn at run time
   } test_t;

   logic               clk;
   logic               rst_n;
   logic               run;
   core_pkg::mem_req_t dbg_req;
   logic               dbg_gnt;
   logic               dbg_rvalid;
   core_pkg::word_t    dbg_rdata;
   logic               halted;
   test_t              tests [NUM_TESTS];
   int                 word_errs;
   int                 flag_errs;

   rv_core_top #(.MEM_AW(MEM_AW)) UUT (
      .clk, .rst_n, .run, .dbg_req, .dbg_gnt, .dbg_rvalid, .dbg_rdata, .halted
   );

   function automatic rv_isa_pkg::instr_u addi_ins(logic [4:0] rd, rs1, logic [11:0] imm);
      addi_ins.i = '{imm, rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_IMM};
   endfunction
   function automatic rv_isa_pkg::instr_u lw_ins(logic [4:0] rd, rs1, logic [11:0] imm);
      lw_ins.i = '{imm, rs1, rv_isa_pkg::F3_LW, rd, rv_isa_pkg::LOAD};
   endfunction
   function automatic rv_isa_pkg::instr_u add_ins(logic [4:0] rd, rs1, rs2);
      add_ins.r = '{rv_isa_pkg::F7_ADD, rs2, rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP};
   endfunction
   function automatic rv_isa_pkg::instr_u sw_ins(logic [4:0] rs2, rs1, logic [11:0] imm);
      sw_ins.s = '{imm[11:5], rs2, rs1, rv_isa_pkg::F3_SW, imm[4:0], rv_isa_pkg::STORE};
   endfunction
   function automatic rv_isa_pkg::instr_u beq_ins(logic [4:0] rs1, rs2, logic [12:0] off);
      beq_ins.b = '{off[12], off[10:5], rs2, rs1, rv_isa_pkg::F3_BEQ, off[4:1], off[11],
                    rv_isa_pkg::BRANCH};
   endfunction
   function automatic rv_isa_pkg::instr_u jal_ins(logic [4:0] rd, logic [20:0] off);
      jal_ins.j = '{off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::JAL};
   endfunction

   task automatic check_word(input string name, input core_pkg::word_t got,
                             input core_pkg::word_t exp);
      if (got !== exp) begin
         word_errs++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         flag_errs++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Called and left at a drive point just after a rising edge
   task automatic dbg_access(input logic we, input core_pkg::word_t addr,
                             input core_pkg::word_t wdata, output core_pkg::word_t rdata);
      dbg_req = '{1'b1, we, addr, wdata};
      @(negedge clk);
      while (!dbg_gnt) @(negedge clk);
      @(posedge clk);   // Granting edge
      #DRIVE_DLY;
      dbg_req = '0;
      rdata   = '0;
      if (!we) begin
         @(negedge clk);
         if (!dbg_rvalid) begin
            word_errs++;
            $display("Debug read of address %h returned no read-valid pulse", addr);
         end
         rdata = dbg_rdata;
         @(posedge clk);
         #DRIVE_DLY;
      end
   endtask

   task automatic fill_tests();
      for (int t = 0; t < NUM_TESTS; t++) begin
         tests[t]          = '0;   // Unused words stay illegal
         tests[t].res_addr = RES_ADDR;
      end
      tests[0].rnd     = 1'b1;   // Two chained addi go in words 0 and 1
      tests[0].prog[2] = sw_ins(5'd2, 5'd0, RES_ADDR[11:0]);
      tests[1].prog[0] = addi_ins(5'd1, 5'd0, 12'd100);
      tests[1].prog[1] = addi_ins(5'd2, 5'd0, -12'sd30);
      tests[1].prog[2] = add_ins(5'd3, 5'd1, 5'd2);
      tests[1].prog[3] = add_ins(5'd0, 5'd1, 5'd2);   // Must not stick
      tests[1].prog[4] = add_ins(5'd4, 5'd3, 5'd0);
      tests[1].prog[5] = sw_ins(5'd4, 5'd0, RES_ADDR[11:0]);
      tests[1].exp_val = 32'd70;
      tests[2].prog[0] = addi_ins(5'd2, 5'd0, 12'd5);
      tests[2].prog[1] = addi_ins(5'd1, 5'd1, 12'd1);
      tests[2].prog[2] = beq_ins(5'd1, 5'd2, 13'd8);   // Exit once count hits 5
      tests[2].prog[3] = beq_ins(5'd0, 5'd0, -13'sd8);
      tests[2].prog[4] = sw_ins(5'd1, 5'd0, RES_ADDR[11:0]);
      tests[2].exp_val = 32'd5;
      tests[3].prog[0] = jal_ins(5'd5, 21'd12);
      tests[3].prog[1] = addi_ins(5'd6, 5'd0, 12'd1);
      tests[3].prog[2] = addi_ins(5'd6, 5'd0, 12'd2);
      tests[3].prog[3] = add_ins(5'd7, 5'd5, 5'd6);   // Link plus skipped x6
      tests[3].prog[4] = sw_ins(5'd7, 5'd0, RES_ADDR[11:0]);
      tests[3].exp_val = 32'd4;
      tests[4].prog[0] = lw_ins(5'd1, 5'd0, DATA_ADDR[11:0]);
      tests[4].prog[1] = sw_ins(5'd1, 5'd0, RES_ADDR[11:0]);
      tests[4].prog[3] = sw_ins(5'd0, 5'd0, RES_ADDR[11:0]);   // Behind the illegal word
      tests[4].exp_val = PRELOAD;
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("Watchdog expired before all programs finished");
      $display("Errors found");
      $finish;
   end

   initial begin
      core_pkg::word_t rd_val;
      logic [11:0]     imm_a;
      logic [11:0]     imm_b;
      word_errs = 0;
      flag_errs = 0;
      rst_n     = 1'b0;
      run       = 1'b0;
      dbg_req   = '0;
      void'($urandom(32'h42fd_4e04));
      fill_tests();
      for (int t = 0; t < NUM_TESTS; t++) begin
         if (tests[t].rnd) begin
            imm_a            = 12'($urandom);
            imm_b            = 12'($urandom);
            tests[t].prog[0] = addi_ins(5'd1, 5'd0, imm_a);
            tests[t].prog[1] = addi_ins(5'd2, 5'd1, imm_b);
            tests[t].exp_val = 32'($signed(imm_a)) + 32'($signed(imm_b));
         end
         @(posedge clk);
         #DRIVE_DLY;
         rst_n = 1'b0;
         run   = 1'b0;
         repeat (RST_CYCLES) @(posedge clk);
         #DRIVE_DLY;
         rst_n = 1'b1;
         check_flag("halted", halted, 1'b0);
         for (int k = 0; k < 12; k++) begin
            dbg_access(1'b1, 32'(k * 4), tests[t].prog[k], rd_val);
         end
         dbg_access(1'b1, DATA_ADDR, PRELOAD, rd_val);
         dbg_access(1'b1, tests[t].res_addr, MARKER, rd_val);
         run = 1'b1;
         while (!halted) @(negedge clk);
         @(posedge clk);
         #DRIVE_DLY;
         run = 1'b0;
         dbg_access(1'b0, tests[t].res_addr, '0, rd_val);
         check_word($sformatf("dbg_rdata program %0d", t), rd_val, tests[t].exp_val);
         check_flag("halted", halted, 1'b1);   // Stays up until reset
      end
      $display("Done: %0d word errors, %0d flag errors", word_errs, flag_errs);
      if (word_errs + flag_errs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- tb.f
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/lsu.sv
verilog/core_sequencer.sv
verilog/mem_arbiter.sv
verilog/unified_mem.sv
verilog/rv_core_top.sv
sim/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the rv_core testbench with Verilator, run it and scan the log
set -o pipefail
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core \
   && ./obj_dir/Vtb_rv_core 2>&1 | tee sim.log \
   && ! grep -q "Errors found" sim.log \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
